// File: hw/pc_word_pkg.sv
`default_nettype none

package pc_word_pkg;

  ////////////////////////////////////////
  // host word layout

  localparam int host_word_width = 32;
  localparam int kind_width = 2;
  localparam int id_width = 6;
  localparam int conf_width = 16;
  // bits between the id and the data, part of the bd payload
  localparam int unused_width = host_word_width - kind_width - id_width - conf_width;
  localparam int bd_data_width = 24;
  localparam int leaf_code_width = 6;

  ////////////////////////////////////////
  // register file and channels

  localparam int num_conf_regs = 64;
  localparam int num_conf_chans = 2;
  // only the low id bits select, higher ids alias
  localparam int reg_sel_width = $clog2(num_conf_regs);
  localparam int chan_sel_width = $clog2(num_conf_chans);
  localparam int fifo_depth = 4;

  // top two bits of the host word
  typedef enum logic [kind_width-1:0] {
    bd_word   = 2'b00,
    reg_word  = 2'b10,
    chan_word = 2'b11
  } word_kind_t;

  // bit 31 low means bd, bit 30 then picks register or channel
  function automatic word_kind_t decode_kind(logic [kind_width-1:0] kind_bits);
    if (!kind_bits[1]) return bd_word;
    else if (!kind_bits[0]) return reg_word;
    else return chan_word;
  endfunction

  // entry i resets to i * 0x0101
  function automatic logic [num_conf_regs-1:0][conf_width-1:0] make_reset_vals();
    logic [num_conf_regs-1:0][conf_width-1:0] vals;
    for (int i = 0; i < num_conf_regs; i++) begin
      vals[i] = conf_width'(i * 'h0101);
    end
    return vals;
  endfunction

  localparam logic [num_conf_regs-1:0][conf_width-1:0] conf_reg_reset_vals =
    make_reset_vals();

endpackage

`default_nettype wire

// File: hw/pc_stream_pkg.sv
`default_nettype none

package pc_stream_pkg;

  // word as it arrives from the host
  // for bd words {unused, data} is the 24 bit payload and id the leaf code
  typedef struct packed {
    logic [pc_word_pkg::kind_width-1:0]   kind;
    logic [pc_word_pkg::id_width-1:0]     id;
    logic [pc_word_pkg::unused_width-1:0] unused;
    logic [pc_word_pkg::conf_width-1:0]   data;
  } host_word_t;

  // chip-bound word, not yet encoded
  typedef struct packed {
    logic [pc_word_pkg::leaf_code_width-1:0] leaf_code;
    logic [pc_word_pkg::bd_data_width-1:0]   payload;
  } bd_word_t;

  // one channel chunk
  typedef struct packed {
    logic [pc_word_pkg::conf_width-1:0] data;
  } conf_chunk_t;

  // assembled channel words, first chunk in the low bits
  typedef struct packed {
    logic [2*pc_word_pkg::conf_width-1:0] data;
  } chan0_word_t;

  typedef struct packed {
    logic [3*pc_word_pkg::conf_width-1:0] data;
  } chan1_word_t;

endpackage

`default_nettype wire

// File: hw/pc_input_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module pc_input_buffer (
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire logic                     stall,
  input  wire logic                     in_valid,
  input  wire pc_stream_pkg::host_word_t in_word,
  output logic                          in_ack,
  output logic                          out_valid,
  output pc_stream_pkg::host_word_t     out_word,
  input  wire logic                     out_ack
);

  // low for the reset cycle so the host sees no ack then
  logic live;
  logic full;
  // set once a word has been offered and not yet taken
  logic offering;
  logic take;
  logic draining;
  pc_stream_pkg::host_word_t held;

  ////////////////////////////////////////
  // handshakes

  // stall hides a held word, but an offer already made stays up
  // until the parser takes it
  assign out_valid = full && (offering || !stall);
  assign draining = out_valid && out_ack;
  // accept into an empty slot or one that empties this cycle
  assign in_ack = live && !stall && (!full || draining);
  assign take = in_valid && in_ack;
  assign out_word = held;

  ////////////////////////////////////////
  // slot state

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      live <= 1'b0;
      full <= 1'b0;
      offering <= 1'b0;
    end else begin
      live <= 1'b1;
      if (take) full <= 1'b1;
      else if (draining) full <= 1'b0;
      offering <= out_valid && !out_ack;
    end
  end

  // payload only
  always_ff @(posedge clk) begin
    if (take) held <= in_word;
  end

endmodule

`default_nettype wire

// File: hw/stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
  parameter type payload_t = logic
) (
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire logic     in_valid,
  input  wire payload_t in_data,
  output logic          in_ack,
  output logic          out_valid,
  output payload_t      out_data,
  input  wire logic     out_ack
);

  localparam int depth = pc_word_pkg::fifo_depth;
  localparam int ptr_width = $clog2(depth);

  payload_t mem [depth];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  // one bit wider than the pointers to tell full from empty
  logic [ptr_width:0] count;
  logic push;
  logic pop;

  assign in_ack = count != (ptr_width + 1)'(depth);
  assign out_valid = count != '0;
  assign out_data = mem[rd_ptr];
  assign push = in_valid && in_ack;
  assign pop = out_valid && out_ack;

  ////////////////////////////////////////
  // pointers and count

  // depth is a power of two so pointers wrap on their own
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_data;
  end

  ////////////////////////////////////////
  // checks

  // sender holds valid and payload until the push
  a_in_stable: assert property (@(posedge clk) disable iff (reset)
    in_valid && !in_ack |=> in_valid && $stable(in_data));

  // a push while full would carry the count past depth
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    count == (ptr_width + 1)'(depth) && !pop |=> count == (ptr_width + 1)'(depth));

endmodule

`default_nettype wire

// File: hw/conf_channel_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module conf_channel_assembler #(
  parameter type word_t = pc_stream_pkg::chan0_word_t
) (
  input  wire logic                       clk,
  input  wire logic                       reset,
  input  wire logic                       in_valid,
  input  wire pc_stream_pkg::conf_chunk_t in_chunk,
  output logic                            in_ack,
  output logic                            out_valid,
  output word_t                           out_word,
  input  wire logic                       out_ack
);

  localparam int word_width = $bits(word_t);
  localparam int chunk_width = pc_word_pkg::conf_width;
  localparam int num_chunks = word_width / chunk_width;
  localparam int cnt_width = (num_chunks > 2) ? $clog2(num_chunks) : 1;
  localparam logic [cnt_width-1:0] last_chunk = cnt_width'(num_chunks - 1);

  logic [cnt_width-1:0] chunk_cnt;
  logic [word_width-1:0] shreg;
  logic take;

  ////////////////////////////////////////
  // handshakes

  // gathering whenever no finished word is waiting
  assign in_ack = !out_valid;
  assign take = in_valid && in_ack;
  assign out_word = word_t'(shreg);

  ////////////////////////////////////////
  // chunk counter and output flag

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      chunk_cnt <= '0;
      out_valid <= 1'b0;
    end else begin
      if (take) begin
        if (chunk_cnt == last_chunk) begin
          chunk_cnt <= '0;
          out_valid <= 1'b1;
        end else begin
          chunk_cnt <= chunk_cnt + 1'b1;
        end
      end else if (out_valid && out_ack) begin
        out_valid <= 1'b0;
      end
    end
  end

  // new chunks enter at the top and move down
  // after the last one the first chunk sits in the low bits
  always_ff @(posedge clk) begin
    if (take) shreg <= {in_chunk.data, shreg[word_width-1:chunk_width]};
  end

  // chunk source keeps valid and data until taken
  a_in_stable: assert property (@(posedge clk) disable iff (reset)
    in_valid && !in_ack |=> in_valid && $stable(in_chunk));

endmodule

`default_nettype wire

// File: hw/pc_word_parser.sv
`timescale 1ns/1ps
`default_nettype none

module pc_word_parser (
  input  wire logic                                clk,
  input  wire logic                                reset,
  input  wire logic                                in_valid,
  input  wire pc_stream_pkg::host_word_t           in_word,
  output logic                                     in_ack,
  output logic [pc_word_pkg::num_conf_regs-1:0][pc_word_pkg::conf_width-1:0] conf_regs,
  output logic                                     bd_valid,
  output pc_stream_pkg::bd_word_t                  bd_word,
  input  wire logic                                bd_ack,
  output logic [pc_word_pkg::num_conf_chans-1:0]   chunk_valid,
  output pc_stream_pkg::conf_chunk_t               chunk,
  input  wire logic [pc_word_pkg::num_conf_chans-1:0] chunk_ack
);

  pc_word_pkg::word_kind_t kind;
  logic [pc_word_pkg::reg_sel_width-1:0] reg_sel;
  logic [pc_word_pkg::chan_sel_width-1:0] chan_sel;

  ////////////////////////////////////////
  // field decode

  assign kind = pc_word_pkg::decode_kind(in_word.kind);
  // id truncated to the bits needed, so ids alias
  assign reg_sel = in_word.id[pc_word_pkg::reg_sel_width-1:0];
  assign chan_sel = in_word.id[pc_word_pkg::chan_sel_width-1:0];

  ////////////////////////////////////////
  // configuration registers

  // written the same edge the register word is acked
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      conf_regs <= pc_word_pkg::conf_reg_reset_vals;
    end else if (in_valid && kind == pc_word_pkg::reg_word) begin
      conf_regs[reg_sel] <= in_word.data;
    end
  end

  ////////////////////////////////////////
  // steering to the queues

  // bd payload is everything below the leaf code
  assign bd_word.leaf_code = in_word.id;
  assign bd_word.payload = {in_word.unused, in_word.data};
  assign bd_valid = in_valid && kind == pc_word_pkg::bd_word;

  // one chunk bus shared by all channels, valid picks the target
  assign chunk.data = in_word.data;

  always_comb begin
    for (int k = 0; k < pc_word_pkg::num_conf_chans; k++) begin
      chunk_valid[k] = in_valid && kind == pc_word_pkg::chan_word &&
                       chan_sel == pc_word_pkg::chan_sel_width'(k);
    end
  end

  // ack follows the chosen target, registers never stall
  always_comb begin
    in_ack = 1'b0;
    if (in_valid) begin
      unique case (kind)
        pc_word_pkg::bd_word:   in_ack = bd_ack;
        pc_word_pkg::reg_word:  in_ack = 1'b1;
        pc_word_pkg::chan_word: in_ack = chunk_ack[chan_sel];
        default:                in_ack = 1'b0;
      endcase
    end
  end

  // a word goes to exactly one queue
  a_one_target: assert property (@(posedge clk) disable iff (reset)
    $onehot0({bd_valid, chunk_valid}));

endmodule

`default_nettype wire

// File: hw/pc_config_top.sv
`timescale 1ns/1ps
`default_nettype none

module pc_config_top (
  input  wire logic                      clk,
  input  wire logic                      reset,
  input  wire logic                      stall,
  input  wire logic                      pc_in_valid,
  input  wire pc_stream_pkg::host_word_t pc_in,
  output logic                           pc_in_ack,
  output logic [pc_word_pkg::num_conf_regs-1:0][pc_word_pkg::conf_width-1:0] conf_regs,
  output logic                           bd_valid,
  output pc_stream_pkg::bd_word_t        bd_word,
  input  wire logic                      bd_ack,
  output logic                           chan0_valid,
  output pc_stream_pkg::chan0_word_t     chan0_word,
  input  wire logic                      chan0_ack,
  output logic                           chan1_valid,
  output pc_stream_pkg::chan1_word_t     chan1_word,
  input  wire logic                      chan1_ack
);

  localparam int nchan = pc_word_pkg::num_conf_chans;

  // buffer to parser
  logic buf_valid;
  logic buf_ack;
  pc_stream_pkg::host_word_t buf_word;

  // parser to queues
  logic pbd_valid;
  logic pbd_ack;
  pc_stream_pkg::bd_word_t pbd_word;
  logic [nchan-1:0] pchunk_valid;
  logic [nchan-1:0] pchunk_ack;
  pc_stream_pkg::conf_chunk_t pchunk;

  // chunk queues to assemblers
  logic [nchan-1:0] qchunk_valid;
  logic [nchan-1:0] qchunk_ack;
  pc_stream_pkg::conf_chunk_t qchunk [nchan];

  pc_input_buffer pc_input_buffer_inst (
    .clk(clk), .reset(reset), .stall(stall),
    .in_valid(pc_in_valid), .in_word(pc_in), .in_ack(pc_in_ack),
    .out_valid(buf_valid), .out_word(buf_word), .out_ack(buf_ack)
  );

  pc_word_parser pc_word_parser_inst (
    .clk(clk), .reset(reset),
    .in_valid(buf_valid), .in_word(buf_word), .in_ack(buf_ack),
    .conf_regs(conf_regs),
    .bd_valid(pbd_valid), .bd_word(pbd_word), .bd_ack(pbd_ack),
    .chunk_valid(pchunk_valid), .chunk(pchunk), .chunk_ack(pchunk_ack)
  );

  ////////////////////////////////////////
  // queues

  stream_fifo #(.payload_t(pc_stream_pkg::bd_word_t)) bd_fifo_inst (
    .clk(clk), .reset(reset),
    .in_valid(pbd_valid), .in_data(pbd_word), .in_ack(pbd_ack),
    .out_valid(bd_valid), .out_data(bd_word), .out_ack(bd_ack)
  );

  // one chunk queue per channel, all fed from the shared chunk bus
  for (genvar k = 0; k < nchan; k++) begin : g_chunk_fifo
    stream_fifo #(.payload_t(pc_stream_pkg::conf_chunk_t)) chunk_fifo_inst (
      .clk(clk), .reset(reset),
      .in_valid(pchunk_valid[k]), .in_data(pchunk), .in_ack(pchunk_ack[k]),
      .out_valid(qchunk_valid[k]), .out_data(qchunk[k]), .out_ack(qchunk_ack[k])
    );
  end

  ////////////////////////////////////////
  // assemblers, 32 and 48 bit

  conf_channel_assembler #(.word_t(pc_stream_pkg::chan0_word_t)) chan0_asm_inst (
    .clk(clk), .reset(reset),
    .in_valid(qchunk_valid[0]), .in_chunk(qchunk[0]), .in_ack(qchunk_ack[0]),
    .out_valid(chan0_valid), .out_word(chan0_word), .out_ack(chan0_ack)
  );

  conf_channel_assembler #(.word_t(pc_stream_pkg::chan1_word_t)) chan1_asm_inst (
    .clk(clk), .reset(reset),
    .in_valid(qchunk_valid[1]), .in_chunk(qchunk[1]), .in_ack(qchunk_ack[1]),
    .out_valid(chan1_valid), .out_word(chan1_word), .out_ack(chan1_ack)
  );

endmodule

`default_nettype wire

// File: verification/pc_config_model.svh
`ifndef PC_CONFIG_MODEL_SVH
`define PC_CONFIG_MODEL_SVH

// mirror of the register file
logic [pc_word_pkg::conf_width-1:0] model_regs [pc_word_pkg::num_conf_regs];
// expected words per output, in send order
pc_stream_pkg::bd_word_t exp_bd_q [$];
logic [31:0] exp_chan0_q [$];
logic [47:0] exp_chan1_q [$];
// chunks still waiting for the rest of their channel word
logic [15:0] pend0_q [$];
logic [15:0] pend1_q [$];

// reset table, both bytes of entry i hold i
task automatic model_reset();
  logic [7:0] b;
  for (int i = 0; i < pc_word_pkg::num_conf_regs; i++) begin
    b = 8'(i);
    model_regs[i] = {b, b};
  end
endtask

// one word taken by the host port
task automatic model_accept(input logic [31:0] w);
  if (!w[31]) begin
    // bd word, leaf code in 29:24 and payload in 23:0
    exp_bd_q.push_back({w[29:24], w[23:0]});
  end else if (!w[30]) begin
    // 6 bit id field, so modulo 64 comes for free
    model_regs[w[29:24]] = w[15:0];
  end else if (!w[24]) begin
    pend0_q.push_back(w[15:0]);
    if (pend0_q.size() == 2) begin
      // first chunk least significant
      exp_chan0_q.push_back({pend0_q[1], pend0_q[0]});
      pend0_q.delete();
    end
  end else begin
    pend1_q.push_back(w[15:0]);
    if (pend1_q.size() == 3) begin
      exp_chan1_q.push_back({pend1_q[2], pend1_q[1], pend1_q[0]});
      pend1_q.delete();
    end
  end
endtask

`endif

// File: verification/pc_config_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pc_config_tb;

  localparam int half_period = 20;
  localparam logic [31:0] seed = 32'd89625;
  localparam int send_timeout = 400;
  localparam int drain_timeout = 400;
  localparam int settle_timeout = 20;

  logic clk;
  logic reset;
  logic stall;
  logic pc_in_valid;
  pc_stream_pkg::host_word_t pc_in;
  logic pc_in_ack;
  logic [pc_word_pkg::num_conf_regs-1:0][pc_word_pkg::conf_width-1:0] conf_regs;
  logic bd_valid;
  pc_stream_pkg::bd_word_t bd_word;
  logic bd_ack;
  logic chan0_valid;
  pc_stream_pkg::chan0_word_t chan0_word;
  logic chan0_ack;
  logic chan1_valid;
  pc_stream_pkg::chan1_word_t chan1_word;
  logic chan1_ack;

  // run bookkeeping
  string test_name;
  int test_errors;
  int total_errors;
  int tests_run;
  int tests_failed;
  // stall and ack probabilities, out of 256
  int stall_level;
  int ack_level;
  logic [31:0] main_rng;

  `include "pc_config_model.svh"

  pc_config_top pc_config_top_inst (
    .clk(clk), .reset(reset), .stall(stall),
    .pc_in_valid(pc_in_valid), .pc_in(pc_in), .pc_in_ack(pc_in_ack),
    .conf_regs(conf_regs),
    .bd_valid(bd_valid), .bd_word(bd_word), .bd_ack(bd_ack),
    .chan0_valid(chan0_valid), .chan0_word(chan0_word), .chan0_ack(chan0_ack),
    .chan1_valid(chan1_valid), .chan1_word(chan1_word), .chan1_ack(chan1_ack)
  );

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  ////////////////////////////////////////
  // checks shared by the processes

  task automatic check_output(input string port, input logic have, input logic [47:0] want,
                              input logic [47:0] got);
    assert (have) else begin
      $display("%s: %s delivered %h with no word expected", test_name, port, got);
      test_errors++;
    end
    if (have) begin
      assert (got == want) else begin
        $display("Mismatch in %s: %s expected %h actual %h", test_name, port, want, got);
        test_errors++;
      end
    end
  endtask

  function automatic logic regs_match();
    for (int i = 0; i < pc_word_pkg::num_conf_regs; i++) begin
      if (conf_regs[i] != model_regs[i]) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic check_regs();
    int waited;
    waited = 0;
    // the last register word may still sit in the input slot
    while (!regs_match() && waited < settle_timeout) begin
      @(negedge clk);
      waited++;
    end
    for (int i = 0; i < pc_word_pkg::num_conf_regs; i++) begin
      assert (conf_regs[i] == model_regs[i]) else begin
        $display("Mismatch in %s: conf_regs[%0d] expected %h actual %h",
                 test_name, i, model_regs[i], conf_regs[i]);
        test_errors++;
      end
    end
  endtask

  ////////////////////////////////////////
  // stall driver and output sinks

  // new stall each falling edge, pc_in_ack must drop with it
  initial begin
    logic [31:0] rng;
    rng = seed ^ 32'h5a5a_0001;
    forever begin
      @(negedge clk);
      rng = xorshift32(rng);
      stall = int'(rng[7:0]) < stall_level;
      #1;
      assert (!(stall && pc_in_ack)) else begin
        $display("%s: pc_in_ack was high while stall was high", test_name);
        test_errors++;
      end
    end
  end

  // each sink samples one step after its ack, the transfer lands on the next rising edge
  initial begin
    logic [31:0] rng;
    logic [47:0] want;
    logic have;
    rng = seed ^ 32'h0bd0_0bd0;
    forever begin
      @(negedge clk);
      rng = xorshift32(rng);
      bd_ack = int'(rng[7:0]) < ack_level;
      #1;
      if (bd_valid && bd_ack) begin
        have = exp_bd_q.size() != 0;
        want = '0;
        if (have) want = 48'(exp_bd_q.pop_front());
        check_output("bd_word", have, want, 48'(bd_word));
      end
    end
  end

  initial begin
    logic [31:0] rng;
    logic [47:0] want;
    logic have;
    rng = seed ^ 32'hc0c0_0000;
    forever begin
      @(negedge clk);
      rng = xorshift32(rng);
      chan0_ack = int'(rng[7:0]) < ack_level;
      #1;
      if (chan0_valid && chan0_ack) begin
        have = exp_chan0_q.size() != 0;
        want = '0;
        if (have) want = 48'(exp_chan0_q.pop_front());
        check_output("chan0_word", have, want, 48'(chan0_word));
      end
    end
  end

  initial begin
    logic [31:0] rng;
    logic [47:0] want;
    logic have;
    rng = seed ^ 32'hc1c1_1111;
    forever begin
      @(negedge clk);
      rng = xorshift32(rng);
      chan1_ack = int'(rng[7:0]) < ack_level;
      #1;
      if (chan1_valid && chan1_ack) begin
        have = exp_chan1_q.size() != 0;
        want = '0;
        if (have) want = exp_chan1_q.pop_front();
        check_output("chan1_word", have, want, chan1_word);
      end
    end
  end

  ////////////////////////////////////////
  // host side

  // called at a falling edge, returns at the falling edge after the transfer
  task automatic send_word(input pc_stream_pkg::host_word_t w);
    logic accepted;
    int waited;
    accepted = 1'b0;
    waited = 0;
    pc_in_valid = 1'b1;
    pc_in = w;
    while (!accepted && waited < send_timeout) begin
      #1;
      accepted = pc_in_ack;
      @(negedge clk);
      waited++;
    end
    pc_in_valid = 1'b0;
    assert (accepted) else begin
      $display("%s: host word %h not accepted within %0d cycles", test_name, w, send_timeout);
      test_errors++;
    end
    if (accepted) model_accept(w);
  endtask

  // kinds mask, bit 0 bd, bit 1 register, bit 2 channel
  task automatic run_traffic(input int count, input logic [2:0] kinds);
    logic [31:0] r;
    logic [1:0] pick;
    pc_stream_pkg::host_word_t w;
    int n;
    n = 0;
    while (n < count) begin
      main_rng = xorshift32(main_rng);
      r = main_rng;
      pick = r[1:0];
      if (pick != 2'd3 && kinds[pick]) begin
        main_rng = xorshift32(main_rng);
        // id, unused bits and data stay random
        w = main_rng;
        case (pick)
          2'd0: w.kind[1] = 1'b0;
          2'd1: w.kind = 2'b10;
          default: w.kind = 2'b11;
        endcase
        send_word(w);
        // 0 to 3 idle cycles
        repeat (int'(r[3:2])) @(negedge clk);
        n++;
      end
    end
  endtask

  function automatic int outstanding();
    return exp_bd_q.size() + exp_chan0_q.size() + exp_chan1_q.size();
  endfunction

  // open all outputs and wait for every expected word
  task automatic drain_outputs();
    int waited;
    waited = 0;
    stall_level = 0;
    ack_level = 256;
    while (outstanding() != 0 && waited < drain_timeout) begin
      @(negedge clk);
      waited++;
    end
    assert (outstanding() == 0) else begin
      $display("%s: %0d expected output words never arrived", test_name, outstanding());
      test_errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, test_errors);
    end
  endtask

  ////////////////////////////////////////
  // sequence

  initial begin
    reset = 1'b1;
    stall = 1'b0;
    pc_in_valid = 1'b0;
    pc_in = '0;
    bd_ack = 1'b0;
    chan0_ack = 1'b0;
    chan1_ack = 1'b0;
    stall_level = 0;
    ack_level = 0;
    main_rng = seed;
    total_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    model_reset();

    begin_test("reset_state");
    repeat (5) begin
      @(negedge clk);
      assert (!pc_in_ack && !bd_valid && !chan0_valid && !chan1_valid) else begin
        $display("%s: a valid or pc_in_ack was high during reset", test_name);
        test_errors++;
      end
    end
    reset = 1'b0;
    check_regs();
    end_test();

    begin_test("register_writes");
    ack_level = 256;
    run_traffic(80, 3'b010);
    drain_outputs();
    check_regs();
    end_test();

    begin_test("bd_passthrough");
    ack_level = 160;
    run_traffic(60, 3'b001);
    drain_outputs();
    end_test();

    // leftover chunks carry over, the model keeps them too
    begin_test("channel_assembly");
    ack_level = 160;
    run_traffic(90, 3'b100);
    drain_outputs();
    end_test();

    begin_test("backpressure_stall");
    stall_level = 80;
    ack_level = 96;
    run_traffic(250, 3'b111);
    drain_outputs();
    check_regs();
    end_test();

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: pc_config.f
+incdir+verification
hw/pc_word_pkg.sv
hw/pc_stream_pkg.sv
hw/pc_input_buffer.sv
hw/stream_fifo.sv
hw/conf_channel_assembler.sv
hw/pc_word_parser.sv
hw/pc_config_top.sv
verification/pc_config_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the pc_config testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module pc_config_tb -f pc_config.f -Mdir obj_dir

./obj_dir/Vpc_config_tb > sim.log 2>&1
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"
